// File: hw/dcache_pkg.sv
package dcache_pkg;

    // address and data widths
    localparam int ADDR_WIDTH   = 32;
    localparam int DATA_WIDTH   = 32;

    // address split as tag | index | offset
    localparam int OFFSET_WIDTH = 5;
    localparam int INDEX_WIDTH  = 4;
    localparam int TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    // cache geometry
    localparam int WAY_NUM        = 2;
    localparam int SET_NUM        = 1 << INDEX_WIDTH;
    localparam int LINE_BYTES     = 1 << OFFSET_WIDTH;
    localparam int BEATS_PER_LINE = LINE_BYTES / (DATA_WIDTH / 8);
    localparam int BEAT_WIDTH     = 3;

    typedef enum logic [1:0] {
        MEM_SIZE_B = 2'd0,
        MEM_SIZE_H = 2'd1,
        MEM_SIZE_W = 2'd2
    } mem_size_t;

    typedef logic [TAG_WIDTH-1:0]        tag_t;
    typedef logic [INDEX_WIDTH-1:0]      index_t;
    typedef logic [OFFSET_WIDTH-1:0]     offset_t;
    typedef logic [BEAT_WIDTH-1:0]       beat_t;
    typedef logic [LINE_BYTES-1:0][7:0]  line_t;

    // one accepted core request
    typedef struct packed {
        logic                  write;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
        mem_size_t             size;
        logic                  sign;
    } req_t;

endpackage

// File: hw/dcache_ifs.sv
interface tag_port_if;
    import dcache_pkg::*;

    // lookup request from the controller
    index_t index;
    tag_t   tag;
    logic   install;
    logic   mark_dirty;

    // lookup result from the tag store
    logic   hit;
    logic   hit_way;
    logic   victim_way;
    logic   victim_dirty;
    tag_t   victim_tag;

    modport ctrl (
        output index,
        output tag,
        output install,
        output mark_dirty,
        input  hit,
        input  hit_way,
        input  victim_way,
        input  victim_dirty,
        input  victim_tag
    );

    modport array (
        input  index,
        input  tag,
        input  install,
        input  mark_dirty,
        output hit,
        output hit_way,
        output victim_way,
        output victim_dirty,
        output victim_tag
    );
endinterface

interface line_port_if;
    import dcache_pkg::*;

    logic                  way;
    index_t                index;
    offset_t               offset;
    mem_size_t             size;
    logic                  sign;
    logic [DATA_WIDTH-1:0] store_data;
    logic                  store_en;
    logic                  fill_en;
    logic [DATA_WIDTH-1:0] fill_data;
    // burst position driven from the beat counter at the top level
    beat_t                 beat;
    logic [DATA_WIDTH-1:0] load_data;
    logic [DATA_WIDTH-1:0] wb_data;

    modport ctrl (
        output way,
        output index,
        output offset,
        output size,
        output sign,
        output store_data,
        output store_en,
        output fill_en,
        output fill_data,
        input  beat
    );

    modport array (
        input  way,
        input  index,
        input  offset,
        input  size,
        input  sign,
        input  store_data,
        input  store_en,
        input  fill_en,
        input  fill_data,
        input  beat,
        output load_data,
        output wb_data
    );
endinterface

// File: hw/dcache_ctrl.sv
module dcache_ctrl (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              req_valid,
    input  logic                              req_write,
    input  logic                              req_signed,
    input  logic [dcache_pkg::ADDR_WIDTH-1:0] req_addr,
    input  logic [dcache_pkg::DATA_WIDTH-1:0] req_wdata,
    input  dcache_pkg::mem_size_t             req_size,
    output logic                              req_ready,
    output logic                              resp_valid,
    output logic                              ar_valid,
    output logic                              r_ready,
    output logic                              aw_valid,
    output logic                              w_valid,
    output logic                              b_ready,
    input  logic                              ar_ready,
    input  logic                              r_valid,
    input  logic                              r_last,
    input  logic                              aw_ready,
    input  logic                              w_ready,
    input  logic                              b_valid,
    input  logic [dcache_pkg::DATA_WIDTH-1:0] r_data,
    output logic [dcache_pkg::ADDR_WIDTH-1:0] ar_addr,
    output logic [dcache_pkg::ADDR_WIDTH-1:0] aw_addr,
    output logic                              beat_count,
    output logic                              beat_clear,
    tag_port_if.ctrl                          tags,
    line_port_if.ctrl                         line
);
    import dcache_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        REFILL_AR,
        REFILL_R,
        WB_AW,
        WB_W,
        WB_B
    } state_t;

    state_t  state;
    state_t  state_next;
    req_t    req_q;
    tag_t    req_tag;
    index_t  req_index;
    offset_t req_offset;
    logic    accept;
    logic    r_fire;
    logic    w_fire;
    logic    w_done;
    logic    store_hit;

    assign req_ready = (state == IDLE);
    assign accept    = req_valid && req_ready;

    // request is held for the whole miss sequence
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q.write <= req_write;
            req_q.addr  <= req_addr;
            req_q.wdata <= req_wdata;
            req_q.size  <= req_size;
            req_q.sign  <= req_signed;
        end
    end

    assign req_tag    = req_q.addr[ADDR_WIDTH-1 -: TAG_WIDTH];
    assign req_index  = req_q.addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign req_offset = req_q.addr[OFFSET_WIDTH-1:0];

    assign r_fire = r_valid && r_ready;
    assign w_fire = w_valid && w_ready;
    // last write-back beat at the position flagged as w_last
    assign w_done = w_fire && (line.beat == beat_t'(BEATS_PER_LINE - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE:      if (accept) state_next = LOOKUP;
            LOOKUP: begin
                if (tags.hit) begin
                    state_next = IDLE;
                end else if (tags.victim_dirty) begin
                    state_next = WB_AW;
                end else begin
                    state_next = REFILL_AR;
                end
            end
            WB_AW:     if (aw_ready) state_next = WB_W;
            WB_W:      if (w_done) state_next = WB_B;
            WB_B:      if (b_valid) state_next = REFILL_AR;
            REFILL_AR: if (ar_ready) state_next = REFILL_R;
            // back to lookup so the hit answers
            REFILL_R:  if (r_fire && r_last) state_next = LOOKUP;
            default:   state_next = IDLE;
        endcase
    end

    assign store_hit  = (state == LOOKUP) && tags.hit && req_q.write;
    assign resp_valid = (state == LOOKUP) && tags.hit;

    // burst channel levels
    assign ar_valid = (state == REFILL_AR);
    assign r_ready  = (state == REFILL_R);
    assign aw_valid = (state == WB_AW);
    assign w_valid  = (state == WB_W);
    assign b_ready  = (state == WB_B);

    assign ar_addr = {req_tag, req_index, {OFFSET_WIDTH{1'b0}}};
    assign aw_addr = {tags.victim_tag, req_index, {OFFSET_WIDTH{1'b0}}};

    // counter restarts whenever an address phase is entered
    assign beat_count = r_fire || w_fire;
    assign beat_clear = ((state == LOOKUP) && !tags.hit) || ((state == WB_B) && b_valid);

    assign tags.index      = req_index;
    assign tags.tag        = req_tag;
    assign tags.install    = r_fire && r_last;
    assign tags.mark_dirty = store_hit;

    assign line.way        = (state == LOOKUP) ? tags.hit_way : tags.victim_way;
    assign line.index      = req_index;
    assign line.offset     = req_offset;
    assign line.size       = req_q.size;
    assign line.sign       = req_q.sign;
    assign line.store_data = req_q.wdata;
    assign line.store_en   = store_hit;
    assign line.fill_en    = r_fire;
    assign line.fill_data  = r_data;

endmodule

// File: hw/dcache_beat_counter.sv
module dcache_beat_counter (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                count,
    input  logic                clear,
    output dcache_pkg::beat_t   beat,
    output logic                last
);
    import dcache_pkg::*;

    beat_t beat_q;

    // clear has priority and only comes outside the data phases
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_q <= '0;
        end else if (clear) begin
            beat_q <= '0;
        end else if (count) begin
            beat_q <= beat_q + beat_t'(1);
        end
    end

    assign beat = beat_q;
    assign last = (beat_q == beat_t'(BEATS_PER_LINE - 1));

endmodule

// File: hw/dcache_tag_array.sv
module dcache_tag_array (
    input  logic       clk,
    input  logic       rst_n,
    tag_port_if.array  tags
);
    import dcache_pkg::*;

    logic valid   [WAY_NUM][SET_NUM];
    logic dirty   [WAY_NUM][SET_NUM];
    tag_t tag_mem [WAY_NUM][SET_NUM];
    // points at the way to replace next
    logic lru     [SET_NUM];

    logic [WAY_NUM-1:0] way_hit;
    logic               victim;

    always_comb begin
        for (int w = 0; w < WAY_NUM; w++) begin
            way_hit[w] = valid[w][tags.index] && (tag_mem[w][tags.index] == tags.tag);
        end
    end

    // way 0 wins if both match
    assign tags.hit     = |way_hit;
    assign tags.hit_way = !way_hit[0] && way_hit[1];

    assign victim            = lru[tags.index];
    assign tags.victim_way   = victim;
    assign tags.victim_dirty = valid[victim][tags.index] && dirty[victim][tags.index];
    assign tags.victim_tag   = tag_mem[victim][tags.index];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < WAY_NUM; w++) begin
                for (int s = 0; s < SET_NUM; s++) begin
                    valid[w][s] <= 1'b0;
                    dirty[w][s] <= 1'b0;
                end
            end
            for (int s = 0; s < SET_NUM; s++) begin
                lru[s] <= 1'b0;
            end
        end else if (tags.install) begin
            // freshly filled line starts clean
            valid[victim][tags.index] <= 1'b1;
            dirty[victim][tags.index] <= 1'b0;
            lru[tags.index]           <= ~victim;
        end else if (tags.mark_dirty) begin
            dirty[tags.hit_way][tags.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tags.install) begin
            tag_mem[victim][tags.index] <= tags.tag;
        end
    end

endmodule

// File: hw/dcache_data_array.sv
module dcache_data_array (
    input  logic        clk,
    line_port_if.array  line
);
    import dcache_pkg::*;

    line_t mem [WAY_NUM][SET_NUM];

    line_t   sel_line;
    offset_t base;
    offset_t beat_base;
    int      lanes;
    logic [7:0] b0;
    logic [7:0] b1;
    logic [7:0] b2;
    logic [7:0] b3;

    assign sel_line  = mem[line.way][line.index];
    assign beat_base = {line.beat, 2'b00};

    // first byte and byte count of the access
    always_comb begin
        case (line.size)
            MEM_SIZE_B: begin
                base  = line.offset;
                lanes = 1;
            end
            MEM_SIZE_H: begin
                base  = {line.offset[OFFSET_WIDTH-1:1], 1'b0};
                lanes = 2;
            end
            default: begin
                base  = {line.offset[OFFSET_WIDTH-1:2], 2'b00};
                lanes = 4;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (line.fill_en) begin
            for (int b = 0; b < 4; b++) begin
                mem[line.way][line.index][beat_base | offset_t'(b)] <= line.fill_data[8*b +: 8];
            end
        end else if (line.store_en) begin
            for (int b = 0; b < 4; b++) begin
                if (b < lanes) begin
                    mem[line.way][line.index][base | offset_t'(b)] <= line.store_data[8*b +: 8];
                end
            end
        end
    end

    // upper bytes only matter for the wider sizes with an aligned base
    assign b0 = sel_line[base];
    assign b1 = sel_line[base | offset_t'(1)];
    assign b2 = sel_line[base | offset_t'(2)];
    assign b3 = sel_line[base | offset_t'(3)];

    always_comb begin
        case (line.size)
            MEM_SIZE_B: begin
                line.load_data = {{24{line.sign && b0[7]}}, b0};
            end
            MEM_SIZE_H: begin
                line.load_data = {{16{line.sign && b1[7]}}, b1, b0};
            end
            default: begin
                line.load_data = {b3, b2, b1, b0};
            end
        endcase
    end

    // write-back beat in little-endian byte order
    assign line.wb_data = {
        sel_line[beat_base | offset_t'(3)],
        sel_line[beat_base | offset_t'(2)],
        sel_line[beat_base | offset_t'(1)],
        sel_line[beat_base]
    };

endmodule

// File: hw/dcache_top.sv
module dcache_top (
    input  logic                              clk,
    input  logic                              rst_n,
    // core side
    input  logic                              req_valid,
    input  logic                              req_write,
    input  logic [dcache_pkg::ADDR_WIDTH-1:0] req_addr,
    input  logic [dcache_pkg::DATA_WIDTH-1:0] req_wdata,
    input  dcache_pkg::mem_size_t             req_size,
    input  logic                              req_signed,
    output logic                              req_ready,
    output logic                              resp_valid,
    output logic [dcache_pkg::DATA_WIDTH-1:0] resp_data,
    // read channels
    output logic                              ar_valid,
    input  logic                              ar_ready,
    output logic [dcache_pkg::ADDR_WIDTH-1:0] ar_addr,
    input  logic                              r_valid,
    output logic                              r_ready,
    input  logic [dcache_pkg::DATA_WIDTH-1:0] r_data,
    input  logic                              r_last,
    // write channels
    output logic                              aw_valid,
    input  logic                              aw_ready,
    output logic [dcache_pkg::ADDR_WIDTH-1:0] aw_addr,
    output logic                              w_valid,
    input  logic                              w_ready,
    output logic [dcache_pkg::DATA_WIDTH-1:0] w_data,
    output logic                              w_last,
    input  logic                              b_valid,
    output logic                              b_ready
);
    tag_port_if  tags ();
    line_port_if line ();

    logic              beat_count;
    logic              beat_clear;
    dcache_pkg::beat_t beat;

    dcache_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_write  (req_write),
        .req_signed (req_signed),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_size   (req_size),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .ar_valid   (ar_valid),
        .r_ready    (r_ready),
        .aw_valid   (aw_valid),
        .w_valid    (w_valid),
        .b_ready    (b_ready),
        .ar_ready   (ar_ready),
        .r_valid    (r_valid),
        .r_last     (r_last),
        .aw_ready   (aw_ready),
        .w_ready    (w_ready),
        .b_valid    (b_valid),
        .r_data     (r_data),
        .ar_addr    (ar_addr),
        .aw_addr    (aw_addr),
        .beat_count (beat_count),
        .beat_clear (beat_clear),
        .tags       (tags.ctrl),
        .line       (line.ctrl)
    );

    dcache_beat_counter u_beat_counter (
        .clk   (clk),
        .rst_n (rst_n),
        .count (beat_count),
        .clear (beat_clear),
        .beat  (beat),
        .last  (w_last)
    );

    dcache_tag_array u_tag_array (
        .clk   (clk),
        .rst_n (rst_n),
        .tags  (tags.array)
    );

    dcache_data_array u_data_array (
        .clk  (clk),
        .line (line.array)
    );

    // burst position shared by fill and write-back
    assign line.beat = beat;
    assign w_data    = line.wb_data;
    assign resp_data = line.load_data;

endmodule

// File: verification/axi_mem_model.sv
module axi_mem_model (
    input  logic        clk,
    input  logic        ar_valid,
    output logic        ar_ready,
    input  logic [31:0] ar_addr,
    output logic        r_valid,
    input  logic        r_ready,
    output logic [31:0] r_data,
    output logic        r_last,
    input  logic        aw_valid,
    output logic        aw_ready,
    input  logic [31:0] aw_addr,
    input  logic        w_valid,
    output logic        w_ready,
    input  logic [31:0] w_data,
    input  logic        w_last,
    output logic        b_valid,
    input  logic        b_ready
);
    // sparse byte store where untouched bytes follow the fill pattern
    logic [7:0]  mem [logic [31:0]];
    logic        rd_busy;
    logic        wr_active;
    logic        b_pend;
    logic [31:0] rd_addr;
    logic [31:0] wr_addr;
    int          rd_beat;
    int          wr_beat;
    logic        ar_fire;
    logic        r_fire;
    logic        aw_fire;
    logic        w_fire;
    logic        b_fire;
    logic [31:0] ar_addr_s;
    logic [31:0] aw_addr_s;
    logic [31:0] w_data_s;
    logic        w_last_s;

    function automatic logic [7:0] mem_byte(input logic [31:0] a);
        logic [31:0] v;
        if (mem.exists(a)) begin
            return mem[a];
        end
        v = a * 32'd7 + 32'd3;
        return v[7:0];
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return {mem_byte(a + 32'd3), mem_byte(a + 32'd2), mem_byte(a + 32'd1), mem_byte(a)};
    endfunction

    // ready about three cycles in four
    function automatic logic stall_free();
        return ($urandom % 4) != 0;
    endfunction

    initial begin
        ar_ready  = 1'b0;
        r_valid   = 1'b0;
        r_data    = '0;
        r_last    = 1'b0;
        aw_ready  = 1'b0;
        w_ready   = 1'b0;
        b_valid   = 1'b0;
        rd_busy   = 1'b0;
        wr_active = 1'b0;
        b_pend    = 1'b0;
        rd_addr   = '0;
        wr_addr   = '0;
        rd_beat   = 0;
        wr_beat   = 0;
        forever begin
            // handshakes are stable between the falling and the next rising edge
            @(negedge clk);
            ar_fire   = ar_valid && ar_ready;
            r_fire    = r_valid && r_ready;
            aw_fire   = aw_valid && aw_ready;
            w_fire    = w_valid && w_ready;
            b_fire    = b_valid && b_ready;
            ar_addr_s = ar_addr;
            aw_addr_s = aw_addr;
            w_data_s  = w_data;
            w_last_s  = w_last;
            @(posedge clk);
            #2;
            if (ar_fire) begin
                rd_busy = 1'b1;
                rd_addr = ar_addr_s;
                rd_beat = 0;
            end
            if (r_fire) begin
                rd_beat++;
                if (rd_beat == 8) begin
                    rd_busy = 1'b0;
                end
            end
            if (aw_fire) begin
                wr_active = 1'b1;
                wr_addr   = aw_addr_s;
                wr_beat   = 0;
            end
            if (w_fire) begin
                for (int i = 0; i < 4; i++) begin
                    mem[wr_addr + 32'(4 * wr_beat + i)] = w_data_s[8*i +: 8];
                end
                wr_beat++;
                if (w_last_s) begin
                    wr_active = 1'b0;
                    b_pend    = 1'b1;
                end
            end
            if (b_fire) begin
                b_pend = 1'b0;
            end
            ar_ready = !rd_busy && stall_free();
            r_valid  = rd_busy && stall_free();
            r_data   = mem_word(rd_addr + 32'(4 * rd_beat));
            r_last   = rd_busy && (rd_beat == 7);
            aw_ready = !wr_active && !b_pend && stall_free();
            w_ready  = wr_active && stall_free();
            b_valid  = b_pend;
        end
    end

endmodule

// File: verification/tb_dcache.sv
module tb_dcache;
    import dcache_pkg::*;

    localparam int MAX_CYCLES   = 20000;
    localparam int RANDOM_COUNT = 400;
    localparam int RESP_LIMIT   = 200;

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    logic        req_write;
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    mem_size_t   req_size;
    logic        req_signed;
    logic        req_ready;
    logic        resp_valid;
    logic [31:0] resp_data;
    logic        ar_valid;
    logic        ar_ready;
    logic [31:0] ar_addr;
    logic        r_valid;
    logic        r_ready;
    logic [31:0] r_data;
    logic        r_last;
    logic        aw_valid;
    logic        aw_ready;
    logic [31:0] aw_addr;
    logic        w_valid;
    logic        w_ready;
    logic [31:0] w_data;
    logic        w_last;
    logic        b_valid;
    logic        b_ready;

    // reference copy of memory as the core sees it
    logic [7:0]  ref_mem [logic [31:0]];
    int          xfer_count = 0;
    int          wb_count = 0;
    int          wb_beat = 0;
    int          cycle_count = 0;
    logic [31:0] wb_addr = '0;

    dcache_top UUT (.*);

    axi_mem_model u_mem (
        .clk      (clk),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar_addr  (ar_addr),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r_data   (r_data),
        .r_last   (r_last),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .aw_addr  (aw_addr),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .w_data   (w_data),
        .w_last   (w_last),
        .b_valid  (b_valid),
        .b_ready  (b_ready)
    );

    always #20 clk = ~clk;

    task automatic stop_failed();
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("CHECK FAILED at time %0t: %s expected 0x%08h, actual 0x%08h",
                 $time, name, expected, actual);
        stop_failed();
    endtask

    task automatic abort_run(input string reason);
        $display("ERROR at time %0t: %s", $time, reason);
        stop_failed();
    endtask

    function automatic logic [7:0] ref_byte(input logic [31:0] a);
        logic [31:0] v;
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        v = a * 32'd7 + 32'd3;
        return v[7:0];
    endfunction

    function automatic logic [31:0] ref_word(input logic [31:0] a);
        return {ref_byte(a + 32'd3), ref_byte(a + 32'd2), ref_byte(a + 32'd1), ref_byte(a)};
    endfunction

    function automatic logic [31:0] aligned_addr(input logic [31:0] a, input mem_size_t size);
        case (size)
            MEM_SIZE_B: return a;
            MEM_SIZE_H: return {a[31:1], 1'b0};
            default:    return {a[31:2], 2'b00};
        endcase
    endfunction

    function automatic logic [31:0] expected_load(input logic [31:0] a, input mem_size_t size,
                                                  input logic sgn);
        logic [31:0] word;
        word = ref_word(aligned_addr(a, size));
        case (size)
            MEM_SIZE_B: return {{24{sgn && word[7]}}, word[7:0]};
            MEM_SIZE_H: return {{16{sgn && word[15]}}, word[15:0]};
            default:    return word;
        endcase
    endfunction

    function automatic logic [22:0] pick_tag(input int k);
        case (k)
            0:       return 23'h000012;
            1:       return 23'h01a5c3;
            default: return 23'h07ff00;
        endcase
    endfunction

    task automatic check_idle_outputs();
        assert (req_ready == 1'b1) else report_mismatch("req_ready", 32'd1, 32'(req_ready));
        assert ({ar_valid, r_ready, aw_valid, w_valid, b_ready, resp_valid} == 6'b0)
            else report_mismatch("ar_valid,r_ready,aw_valid,w_valid,b_ready,resp_valid",
                                 32'd0,
                                 32'({ar_valid, r_ready, aw_valid, w_valid, b_ready, resp_valid}));
    endtask

    // one request from drive to response with a latency check on hits
    task automatic run_request(input logic wr, input logic [31:0] a, input logic [31:0] wdata,
                               input mem_size_t size, input logic sgn, input logic expect_hit);
        logic [31:0] exp;
        logic [31:0] base;
        int          latency;
        int          xfer_before;
        exp        = expected_load(a, size, sgn);
        req_valid  = 1'b1;
        req_write  = wr;
        req_addr   = a;
        req_wdata  = wdata;
        req_size   = size;
        req_signed = sgn;
        while (!req_ready) begin
            @(posedge clk);
            #2;
        end
        xfer_before = xfer_count;
        @(posedge clk);
        #2;
        req_valid = 1'b0;
        latency   = 1;
        while (!resp_valid) begin
            if (latency > RESP_LIMIT) begin
                abort_run("no response to an accepted request");
            end
            @(posedge clk);
            #2;
            latency++;
        end
        assert (resp_data == exp) else report_mismatch("resp_data", exp, resp_data);
        if (expect_hit) begin
            assert (latency == 1) else report_mismatch("hit latency", 32'd1, 32'(latency));
            assert (xfer_count == xfer_before)
                else report_mismatch("memory transfers", 32'(xfer_before), 32'(xfer_count));
        end
        if (wr) begin
            base = aligned_addr(a, size);
            for (int i = 0; i < 4; i++) begin
                if (size == MEM_SIZE_W || (size == MEM_SIZE_H && i < 2) || i == 0) begin
                    ref_mem[base + 32'(i)] = wdata[8*i +: 8];
                end
            end
        end
    endtask

    // one response per request and never back to back
    assert property (@(posedge clk) disable iff (!rst_n) resp_valid |=> !resp_valid)
        else report_mismatch("resp_valid pulse width", 32'd1, 32'd2);

    assert property (@(posedge clk) disable iff (!rst_n)
        req_ready |-> !(resp_valid || ar_valid || r_ready || aw_valid || w_valid || b_ready))
        else report_mismatch("channel activity while req_ready", 32'd0, 32'd1);

    // write-back beats must carry the reference bytes of the evicted line
    always @(negedge clk) begin : bus_monitor
        logic [31:0] exp_beat;
        logic [31:0] exp_line;
        if (rst_n) begin
            if (ar_valid && ar_ready) begin
                xfer_count++;
                // refill reads the line of the pending request
                exp_line = {req_addr[31:5], 5'd0};
                assert (ar_addr == exp_line) else report_mismatch("ar_addr", exp_line, ar_addr);
            end
            if (aw_valid && aw_ready) begin
                xfer_count++;
                wb_count++;
                wb_addr = aw_addr;
                wb_beat = 0;
            end
            if (w_valid && w_ready) begin
                exp_beat = ref_word(wb_addr + 32'(4 * wb_beat));
                assert (w_data == exp_beat) else report_mismatch("w_data", exp_beat, w_data);
                assert (w_last == (wb_beat == 7))
                    else report_mismatch("w_last", 32'(wb_beat == 7), 32'(w_last));
                wb_beat++;
            end
            if (b_valid && b_ready) begin
                assert (wb_beat == 8)
                    else report_mismatch("write-back beat count", 32'd8, 32'(wb_beat));
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            abort_run("run did not finish within the cycle limit");
        end
    end

    initial begin
        logic [31:0] line_a;
        logic [31:0] line_b;
        logic [31:0] line_c;
        int          wb_before;
        void'($urandom(47));
        clk        = 1'b0;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req_write  = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        req_size   = MEM_SIZE_W;
        req_signed = 1'b0;
        @(posedge clk);
        #2;
        check_idle_outputs();
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_idle_outputs();

        // every size and offset of one line with hits after the first load
        line_a = {pick_tag(0), 4'd1, 5'd0};
        run_request(1'b0, line_a, '0, MEM_SIZE_B, 1'b0, 1'b0);
        for (int off = 0; off < 32; off++) begin
            run_request(1'b0, line_a + 32'(off), '0, MEM_SIZE_B, 1'b0, 1'b1);
            run_request(1'b0, line_a + 32'(off), '0, MEM_SIZE_B, 1'b1, 1'b1);
            if (off % 2 == 0) begin
                run_request(1'b0, line_a + 32'(off), '0, MEM_SIZE_H, 1'b0, 1'b1);
                run_request(1'b0, line_a + 32'(off), '0, MEM_SIZE_H, 1'b1, 1'b1);
            end
            if (off % 4 == 0) begin
                run_request(1'b0, line_a + 32'(off), '0, MEM_SIZE_W, 1'b0, 1'b1);
                run_request(1'b0, line_a + 32'(off), '0, MEM_SIZE_W, 1'b1, 1'b1);
            end
        end

        // store hits merged into neighbours
        line_b = {pick_tag(1), 4'd2, 5'd0};
        run_request(1'b0, line_b + 32'd8, '0, MEM_SIZE_W, 1'b0, 1'b0);
        run_request(1'b1, line_b + 32'd9, 32'h0000_00a7, MEM_SIZE_B, 1'b0, 1'b1);
        run_request(1'b0, line_b + 32'd8, '0, MEM_SIZE_W, 1'b0, 1'b1);
        run_request(1'b0, line_b + 32'd9, '0, MEM_SIZE_B, 1'b1, 1'b1);
        run_request(1'b0, line_b + 32'd10, '0, MEM_SIZE_B, 1'b0, 1'b1);
        run_request(1'b1, line_b + 32'd14, 32'h0000_f00d, MEM_SIZE_H, 1'b0, 1'b1);
        run_request(1'b0, line_b + 32'd12, '0, MEM_SIZE_W, 1'b0, 1'b1);
        run_request(1'b0, line_b + 32'd14, '0, MEM_SIZE_H, 1'b1, 1'b1);
        run_request(1'b1, line_b + 32'd20, 32'h8765_4321, MEM_SIZE_W, 1'b0, 1'b1);
        run_request(1'b0, line_b + 32'd21, '0, MEM_SIZE_B, 1'b1, 1'b1);
        run_request(1'b0, line_b + 32'd22, '0, MEM_SIZE_H, 1'b0, 1'b1);

        // three lines in set 9 evict the dirty one in way 0
        line_a = {pick_tag(0), 4'd9, 5'd0};
        line_b = {pick_tag(1), 4'd9, 5'd0};
        line_c = {pick_tag(2), 4'd9, 5'd0};
        run_request(1'b0, line_a, '0, MEM_SIZE_W, 1'b0, 1'b0);
        run_request(1'b1, line_a + 32'd4, 32'hdead_beef, MEM_SIZE_W, 1'b0, 1'b1);
        run_request(1'b1, line_a + 32'd17, 32'h0000_005a, MEM_SIZE_B, 1'b0, 1'b1);
        run_request(1'b0, line_b, '0, MEM_SIZE_W, 1'b0, 1'b0);
        wb_before = wb_count;
        run_request(1'b0, line_c, '0, MEM_SIZE_W, 1'b0, 1'b0);
        assert (wb_count == wb_before + 1)
            else report_mismatch("write-back bursts", 32'(wb_before + 1), 32'(wb_count));
        assert (wb_addr == line_a) else report_mismatch("aw_addr", line_a, wb_addr);
        run_request(1'b0, line_a + 32'd4, '0, MEM_SIZE_W, 1'b0, 1'b0);
        run_request(1'b0, line_a + 32'd17, '0, MEM_SIZE_B, 1'b1, 1'b1);

        // random traffic over three tags and all sets
        for (int n = 0; n < RANDOM_COUNT; n++) begin
            run_request(1'(($urandom % 2)),
                        {pick_tag(int'($urandom % 3)), 9'($urandom)},
                        $urandom,
                        mem_size_t'($urandom % 3),
                        1'(($urandom % 2)),
                        1'b0);
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

// File: verilog.f
hw/dcache_pkg.sv
hw/dcache_ifs.sv
hw/dcache_ctrl.sv
hw/dcache_beat_counter.sv
hw/dcache_tag_array.sv
hw/dcache_data_array.sv
hw/dcache_top.sv
verification/axi_mem_model.sv
verification/tb_dcache.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_dcache \
    -f verilog.f \
    -o tb_dcache_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_dcache_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
fi

if grep -q "^Done: no errors$" sim.log; then
    exit 0
fi
exit 1
